// ==== source/hps_pkg.sv ====
//////////////////////////////
// widths, counts and command codes shared by the host I/O bridge
// imported by every RTL module and by the testbench
//////////////////////////////
package hps_pkg;

	// host bus and byte widths
	localparam int BUS_W    = 16;
	localparam int DATA_W   = 8;

	// sector buffer and virtual disks
	localparam int BUFF_AW  = 14;
	localparam int VDNUM    = 4;
	localparam int DISK_W   = 2;

	// download address, word counter saturates at 15
	localparam int IOCTL_AW = 27;
	localparam int CNT_W    = 4;

	// user channel payloads
	localparam int JOY_W    = 32;
	localparam int STATUS_W = 128;
	localparam int KEY_W    = 11;

	// user channel commands
	typedef enum logic [7:0] {
		CMD_CFG        = 8'h01,
		CMD_JOY0       = 8'h02,
		CMD_JOY1       = 8'h03,
		CMD_KBD        = 8'h05,
		CMD_SD_STAT    = 8'h16,
		CMD_SD_WRITE   = 8'h17,
		CMD_SD_READ    = 8'h18,
		CMD_STATUS     = 8'h1e,
		CMD_STATUS_GET = 8'h29
	} uio_cmd_e;

	// file channel commands
	typedef enum logic [7:0] {
		FIO_FILE_TX     = 8'h53,
		FIO_FILE_TX_DAT = 8'h54,
		FIO_FILE_INDEX  = 8'h55,
		FIO_FILE_INFO   = 8'h56
	} fio_cmd_e;

	// first TX word that marks an upload, ignored here
	localparam logic [7:0] FIO_MAGIC_UPLOAD = 8'hAA;

endpackage

// ==== source/hps_bus_port.sv ====
//////////////////////////////
// host bus front end: word counter, command latch and response mux
//////////////////////////////
`timescale 1ns/1ns

module hps_bus_port import hps_pkg::*; (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              io_strobe,
	input  logic              io_enable,
	input  logic              fp_enable,
	input  logic [BUS_W-1:0]  io_din,
	input  logic [BUS_W-1:0]  uio_dout,
	input  logic [BUS_W-1:0]  sd_dout,
	output logic [BUS_W-1:0]  cmd_word,
	output logic [CNT_W-1:0]  word_cnt,
	output logic              uio_word,
	output logic              fio_word,
	output logic              uio_end,
	output logic [BUS_W-1:0]  io_dout
);

	logic io_enable_q;
	logic any_enable;

	assign any_enable = io_enable | fp_enable;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cmd_word    <= '0;
			word_cnt    <= '0;
			io_enable_q <= 1'b0;
			uio_end     <= 1'b0;
		end else begin
			io_enable_q <= io_enable;
			uio_end     <= io_enable_q & ~io_enable;
			if (!any_enable) begin
				word_cnt <= '0;
			end else if (io_strobe) begin
				if (word_cnt == '0)
					cmd_word <= io_din;
				// saturate, long transfers keep counting at 15
				if (word_cnt != '1)
					word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	// data word strobes, the command word never reaches a peer
	assign uio_word = io_strobe & io_enable & (word_cnt != '0);
	assign fio_word = io_strobe & fp_enable & (word_cnt != '0);

	always_comb begin
		if (!io_enable)
			io_dout = '0;
		else if (cmd_word[7:0] == CMD_SD_STAT || cmd_word[7:0] == CMD_SD_READ)
			io_dout = sd_dout;
		else
			io_dout = uio_dout;
	end

endmodule

// ==== source/user_cmd_decoder.sv ====
//////////////////////////////
// user channel: config, joysticks, status vector and status-set read-back
// also forwards keyboard bytes to the key decoder
//////////////////////////////
`timescale 1ns/1ns

module user_cmd_decoder import hps_pkg::*; (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic [BUS_W-1:0]    cmd_word,
	input  logic [CNT_W-1:0]    word_cnt,
	input  logic                uio_word,
	input  logic [BUS_W-1:0]    io_din,
	input  logic [STATUS_W-1:0] status_in,
	input  logic                status_set,
	output logic [BUS_W-1:0]    uio_dout,
	output logic [1:0]          cfg_buttons,
	output logic                forced_scandoubler,
	output logic [JOY_W-1:0]    joystick_0,
	output logic [JOY_W-1:0]    joystick_1,
	output logic [STATUS_W-1:0] status,
	output logic [DATA_W-1:0]   kbd_byte,
	output logic                kbd_byte_we,
	output logic                kbd_cmd_start
);

	uio_cmd_e            cmd;
	logic [2:0]          word_idx;
	logic                word_in_status;
	logic                status_set_q;
	logic                status_rise;
	logic [3:0]          stflg;
	logic [STATUS_W-1:0] status_req;
	logic                new_cmd;
	logic                kbd_skip;

	assign cmd            = uio_cmd_e'(cmd_word[7:0]);
	// words 1..8 map to slices 0..7
	assign word_idx       = word_cnt[2:0] - 3'd1;
	assign word_in_status = (word_cnt != '0) && (word_cnt <= CNT_W'(8));
	assign status_rise    = status_set & ~status_set_q;

	// one cycle after the command word is latched
	assign kbd_cmd_start  = new_cmd && (word_cnt != '0) && (cmd == CMD_KBD);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			uio_dout           <= '0;
			cfg_buttons        <= '0;
			forced_scandoubler <= 1'b0;
			joystick_0         <= '0;
			joystick_1         <= '0;
			status             <= '0;
			status_set_q       <= 1'b0;
			stflg              <= '0;
			new_cmd            <= 1'b0;
			kbd_skip           <= 1'b0;
			kbd_byte_we        <= 1'b0;
		end else begin
			status_set_q <= status_set;
			new_cmd      <= (word_cnt == '0);
			kbd_byte_we  <= 1'b0;
			if (status_rise)
				stflg <= stflg + 1'b1;

			if (word_cnt == '0) begin
				kbd_skip <= 1'b0;
				// answer to word 0 ready by the time the command is latched
				if (io_din[7:0] == CMD_STATUS_GET)
					uio_dout <= {8'h00, 4'hA, stflg};
				else
					uio_dout <= '0;
			end else if (uio_word) begin
				uio_dout <= '0;
				case (cmd)
					CMD_CFG: begin
						cfg_buttons        <= io_din[1:0];
						forced_scandoubler <= io_din[4];
					end
					CMD_JOY0: begin
						if (word_cnt == CNT_W'(1))
							joystick_0[15:0] <= io_din;
						else if (word_cnt == CNT_W'(2))
							joystick_0[31:16] <= io_din;
					end
					CMD_JOY1: begin
						if (word_cnt == CNT_W'(1))
							joystick_1[15:0] <= io_din;
						else if (word_cnt == CNT_W'(2))
							joystick_1[31:16] <= io_din;
					end
					CMD_STATUS: begin
						if (word_in_status)
							status[{word_idx, 4'b0000} +: BUS_W] <= io_din;
					end
					CMD_STATUS_GET: begin
						if (word_in_status)
							uio_dout <= status_req[{word_idx, 4'b0000} +: BUS_W];
					end
					CMD_KBD: begin
						// 0xff high byte means the host drops the rest
						if (&io_din[15:8])
							kbd_skip <= 1'b1;
						else if (!kbd_skip)
							kbd_byte_we <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_rise)
			status_req <= status_in;
		if (uio_word && cmd == CMD_KBD)
			kbd_byte <= io_din[7:0];
	end

endmodule

// ==== source/ps2_key_decoder.sv ====
//////////////////////////////
// builds key events from raw keyboard bytes at the end of a keyboard command
//////////////////////////////
`timescale 1ns/1ns

module ps2_key_decoder import hps_pkg::*; (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              kbd_cmd_start,
	input  logic [DATA_W-1:0] kbd_byte,
	input  logic              kbd_byte_we,
	input  logic              uio_end,
	input  logic              cmd_is_kbd,
	output logic [KEY_W-1:0]  ps2_key
);

	logic [31:0] key_raw;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_code;

	// newest byte sits in 7:0
	assign pressed  = (key_raw[15:8] != 8'hF0);
	assign extended = pressed ? (key_raw[15:8] == 8'hE0) : (key_raw[23:16] == 8'hE0);

	always_comb begin
		key_code = {pressed, extended, key_raw[7:0]};
		// print screen and pause sequences
		case (key_raw)
			32'hE012E07C: key_code = 10'h37C;
			32'h7CE0F012: key_code = 10'h17C;
			32'hF014F077: key_code = 10'h377;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			key_raw <= '0;
			ps2_key <= '0;
		end else begin
			if (kbd_cmd_start)
				key_raw <= kbd_byte_we ? {24'h000000, kbd_byte} : 32'h0;
			else if (kbd_byte_we)
				key_raw <= {key_raw[23:0], kbd_byte};
			if (uio_end && cmd_is_kbd)
				ps2_key <= {~ps2_key[10], key_code};
		end
	end

endmodule

// ==== source/sd_disk_arbiter.sv ====
//////////////////////////////
// virtual disk requests, round-robin choice and sector buffer transfers
//////////////////////////////
`timescale 1ns/1ns

module sd_disk_arbiter import hps_pkg::*; (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic [BUS_W-1:0]   cmd_word,
	input  logic [CNT_W-1:0]   word_cnt,
	input  logic               uio_word,
	input  logic               io_strobe_first,
	input  logic [BUS_W-1:0]   io_din,
	input  logic [31:0]        sd_lba [VDNUM],
	input  logic [VDNUM-1:0]   sd_rd,
	input  logic [VDNUM-1:0]   sd_wr,
	input  logic [DATA_W-1:0]  sd_buff_din [VDNUM],
	output logic [BUS_W-1:0]   sd_dout,
	output logic [VDNUM-1:0]   sd_ack,
	output logic [BUFF_AW-1:0] sd_buff_addr,
	output logic [DATA_W-1:0]  sd_buff_dout,
	output logic               sd_buff_wr
);

	logic [DISK_W-1:0] sd_rrb;
	logic [DISK_W-1:0] sdn;
	logic [DISK_W-1:0] sdn_r;
	logic [DISK_W-1:0] sdn_ack;
	logic [1:0]        b_wr;
	logic              is_sd_xfer;

	// first requesting disk counting up from the pointer
	always_comb begin
		int n;
		sdn = '0;
		for (int i = VDNUM - 1; i >= 0; i--) begin
			n = i + int'(sd_rrb);
			if (n >= VDNUM)
				n = n - VDNUM;
			if (sd_wr[n] | sd_rd[n])
				sdn = DISK_W'(n);
		end
	end

	assign is_sd_xfer = (io_din[7:0] == CMD_SD_WRITE) || (io_din[7:0] == CMD_SD_READ);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			sd_rrb       <= '0;
			sdn_r        <= '0;
			sdn_ack      <= '0;
			sd_dout      <= '0;
			sd_ack       <= '0;
			sd_buff_addr <= '0;
			sd_buff_wr   <= 1'b0;
			b_wr         <= '0;
		end else begin
			// write pulse, then the address step one cycle later
			sd_buff_wr <= b_wr[0];
			b_wr       <= {b_wr[0], 1'b0};
			if (b_wr[1] && !(&sd_buff_addr))
				sd_buff_addr <= sd_buff_addr + 1'b1;

			if (io_strobe_first) begin
				sd_dout <= '0;
				if (io_din[7:0] == CMD_SD_STAT) begin
					sd_dout <= {1'b1, 10'b0, sdn, 1'b0, sd_wr[sdn], sd_rd[sdn]};
					sdn_r   <= sdn;
				end
				if (is_sd_xfer) begin
					sd_ack       <= VDNUM'(1) << io_din[8 +: DISK_W];
					sdn_ack      <= io_din[8 +: DISK_W];
					sd_buff_addr <= '0;
				end
			end else if (word_cnt == '0) begin
				sd_ack <= '0;
			end else if (uio_word) begin
				sd_dout <= '0;
				case (cmd_word[7:0])
					CMD_SD_STAT: begin
						if (word_cnt == CNT_W'(1))
							sd_rrb <= (sd_rrb == DISK_W'(VDNUM - 1)) ? '0 : sd_rrb + 1'b1;
						else if (word_cnt == CNT_W'(2))
							sd_dout <= sd_lba[sdn_r][15:0];
						else if (word_cnt == CNT_W'(3))
							sd_dout <= sd_lba[sdn_r][31:16];
					end
					CMD_SD_WRITE: b_wr[0] <= 1'b1;
					CMD_SD_READ: begin
						if (!(&sd_buff_addr))
							sd_buff_addr <= sd_buff_addr + 1'b1;
						sd_dout <= BUS_W'(sd_buff_din[sdn_ack]);
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (uio_word && cmd_word[7:0] == CMD_SD_WRITE)
			sd_buff_dout <= io_din[DATA_W-1:0];
	end

endmodule

// ==== source/file_loader.sv ====
//////////////////////////////
// file channel, download only: index, extension, start address, data writes
//////////////////////////////
`timescale 1ns/1ns

module file_loader import hps_pkg::*; (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic [BUS_W-1:0]    cmd_word,
	input  logic [CNT_W-1:0]    word_cnt,
	input  logic                fio_word,
	input  logic [BUS_W-1:0]    io_din,
	output logic                ioctl_download,
	output logic [15:0]         ioctl_index,
	output logic [IOCTL_AW-1:0] ioctl_addr,
	output logic [DATA_W-1:0]   ioctl_dout,
	output logic                ioctl_wr,
	output logic [31:0]         ioctl_file_ext
);

	fio_cmd_e            cmd;
	logic [IOCTL_AW-1:0] addr;
	logic                wr;
	logic                tx_ctrl;
	logic                tx_start;
	logic                tx_stop;
	logic                dat_we;

	assign cmd      = fio_cmd_e'(cmd_word[7:0]);
	assign tx_ctrl  = fio_word && (cmd == FIO_FILE_TX) && (word_cnt == CNT_W'(1));
	// the upload marker is ignored
	assign tx_start = tx_ctrl && (io_din[7:0] != FIO_MAGIC_UPLOAD) && (io_din[7:0] != 8'h00);
	assign tx_stop  = tx_ctrl && (io_din[7:0] == 8'h00);
	assign dat_we   = fio_word && (cmd == FIO_FILE_TX_DAT) && ioctl_download;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ioctl_download <= 1'b0;
			wr             <= 1'b0;
			ioctl_wr       <= 1'b0;
		end else begin
			ioctl_wr <= wr;
			wr       <= dat_we;
			if (tx_start)
				ioctl_download <= 1'b1;
			else if (tx_stop)
				ioctl_download <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (fio_word) begin
			case (cmd)
				FIO_FILE_INFO: begin
					if (word_cnt == CNT_W'(1))
						ioctl_file_ext[31:16] <= io_din;
					else if (word_cnt == CNT_W'(2))
						ioctl_file_ext[15:0] <= io_din;
				end
				FIO_FILE_INDEX: ioctl_index <= io_din;
				FIO_FILE_TX: begin
					if (tx_start)
						addr <= '0;
					else if (tx_stop && ioctl_download)
						ioctl_addr <= addr;
					if (word_cnt == CNT_W'(2)) begin
						ioctl_addr[15:0] <= io_din;
						addr[15:0]       <= io_din;
					end else if (word_cnt == CNT_W'(3)) begin
						ioctl_addr[IOCTL_AW-1:16] <= io_din[IOCTL_AW-17:0];
						addr[IOCTL_AW-1:16]       <= io_din[IOCTL_AW-17:0];
					end
				end
				FIO_FILE_TX_DAT: begin
					if (dat_we) begin
						ioctl_addr <= addr;
						ioctl_dout <= io_din[DATA_W-1:0];
						addr       <= addr + 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== source/hps_io.sv ====
//////////////////////////////
// host I/O bridge top, bus port plus user, key, disk and file peers
//////////////////////////////
`timescale 1ns/1ns

module hps_io import hps_pkg::*; (
	input  logic                clk_sys,
	input  logic                rst_n,
	// host bus
	input  logic                io_strobe,
	input  logic                io_enable,
	input  logic                fp_enable,
	input  logic [BUS_W-1:0]    io_din,
	output logic [BUS_W-1:0]    io_dout,
	// user channel
	output logic [1:0]          buttons,
	output logic                forced_scandoubler,
	output logic [JOY_W-1:0]    joystick_0,
	output logic [JOY_W-1:0]    joystick_1,
	output logic [STATUS_W-1:0] status,
	input  logic [STATUS_W-1:0] status_in,
	input  logic                status_set,
	output logic [KEY_W-1:0]    ps2_key,
	// virtual disks
	input  logic [31:0]         sd_lba [VDNUM],
	input  logic [VDNUM-1:0]    sd_rd,
	input  logic [VDNUM-1:0]    sd_wr,
	output logic [VDNUM-1:0]    sd_ack,
	output logic [BUFF_AW-1:0]  sd_buff_addr,
	output logic [DATA_W-1:0]   sd_buff_dout,
	input  logic [DATA_W-1:0]   sd_buff_din [VDNUM],
	output logic                sd_buff_wr,
	// download
	output logic                ioctl_download,
	output logic [15:0]         ioctl_index,
	output logic [IOCTL_AW-1:0] ioctl_addr,
	output logic [DATA_W-1:0]   ioctl_dout,
	output logic                ioctl_wr,
	output logic [31:0]         ioctl_file_ext
);

	logic [BUS_W-1:0]  cmd_word;
	logic [CNT_W-1:0]  word_cnt;
	logic              uio_word;
	logic              fio_word;
	logic              uio_end;
	logic [BUS_W-1:0]  uio_dout;
	logic [BUS_W-1:0]  sd_dout;
	logic [DATA_W-1:0] kbd_byte;
	logic              kbd_byte_we;
	logic              kbd_cmd_start;
	logic              cmd_is_kbd;
	logic              io_strobe_first;

	assign cmd_is_kbd      = (cmd_word[7:0] == CMD_KBD);
	assign io_strobe_first = io_strobe & io_enable & (word_cnt == '0);

	hps_bus_port bus_port_i (
		.clk_sys, .rst_n, .io_strobe, .io_enable, .fp_enable, .io_din,
		.uio_dout, .sd_dout, .cmd_word, .word_cnt, .uio_word, .fio_word,
		.uio_end, .io_dout
	);

	user_cmd_decoder user_cmd_i (
		.clk_sys, .rst_n, .cmd_word, .word_cnt, .uio_word, .io_din,
		.status_in, .status_set, .uio_dout, .cfg_buttons(buttons),
		.forced_scandoubler, .joystick_0, .joystick_1, .status,
		.kbd_byte, .kbd_byte_we, .kbd_cmd_start
	);

	ps2_key_decoder ps2_key_i (
		.clk_sys, .rst_n, .kbd_cmd_start, .kbd_byte, .kbd_byte_we,
		.uio_end, .cmd_is_kbd, .ps2_key
	);

	sd_disk_arbiter sd_arb_i (
		.clk_sys, .rst_n, .cmd_word, .word_cnt, .uio_word, .io_strobe_first,
		.io_din, .sd_lba, .sd_rd, .sd_wr, .sd_buff_din, .sd_dout, .sd_ack,
		.sd_buff_addr, .sd_buff_dout, .sd_buff_wr
	);

	file_loader file_loader_i (
		.clk_sys, .rst_n, .cmd_word, .word_cnt, .fio_word, .io_din,
		.ioctl_download, .ioctl_index, .ioctl_addr, .ioctl_dout, .ioctl_wr,
		.ioctl_file_ext
	);

endmodule

// ==== verification/hps_tb_tasks.svh ====
//////////////////////////////
// host bus transactions, bounded wait loops and typed compare tasks
// included inside the testbench module
//////////////////////////////

// one data word, response sampled on the falling edge after the strobe
task automatic send_word(input logic [BUS_W-1:0] w);
	@(posedge clk_sys);
	io_strobe <= 1'b1;
	io_din    <= w;
	@(posedge clk_sys);
	io_strobe <= 1'b0;
	@(negedge clk_sys);
	resp_q.push_back(io_dout);
endtask

task automatic start_words(input logic [BUS_W-1:0] cmd);
	words_q.delete();
	words_q.push_back(cmd);
endtask

// whole transaction from words_q, fp selects the file channel
task automatic host_xfer(input bit fp);
	resp_q.delete();
	@(posedge clk_sys);
	io_enable <= ~fp;
	fp_enable <= fp;
	foreach (words_q[i])
		send_word(words_q[i]);
	@(posedge clk_sys);
	io_enable <= 1'b0;
	fp_enable <= 1'b0;
	@(posedge clk_sys);
endtask

task automatic report_timeout(input string what);
	$display("ERROR at %0t ns: timed out waiting for %s", $time, what);
	errors++;
	test_errors++;
endtask

task automatic wait_key_change(input logic [KEY_W-1:0] old);
	int n;
	n = 0;
	while (ps2_key == old && n < 20) begin
		@(negedge clk_sys);
		n++;
	end
	if (ps2_key == old)
		report_timeout("a new key event");
endtask

// file_ch picks the ioctl monitor queue, else the sector buffer one
task automatic wait_writes(input bit file_ch, input int want);
	int n;
	n = 0;
	while ((file_ch ? io_wr_q.size() : sd_wr_q.size()) < want && n < 100) begin
		@(negedge clk_sys);
		n++;
	end
	if ((file_ch ? io_wr_q.size() : sd_wr_q.size()) < want)
		report_timeout(file_ch ? "ioctl_wr pulses" : "sd_buff_wr pulses");
endtask

task automatic wait_download_low();
	int n;
	n = 0;
	while (ioctl_download && n < 20) begin
		@(negedge clk_sys);
		n++;
	end
	if (ioctl_download)
		report_timeout("ioctl_download to fall");
endtask

task automatic mismatch(input string name, input logic [159:0] got, input logic [159:0] exp);
	$display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
	errors++;
	test_errors++;
endtask

task automatic check_joy(input string name, input logic [JOY_W-1:0] got,
		input logic [JOY_W-1:0] exp);
	checks++;
	if (got !== exp)
		mismatch(name, 160'(got), 160'(exp));
endtask

task automatic check_status(input string name, input logic [STATUS_W-1:0] got,
		input logic [STATUS_W-1:0] exp);
	checks++;
	if (got !== exp)
		mismatch(name, 160'(got), 160'(exp));
endtask

task automatic check_key(input string name, input logic [KEY_W-1:0] got,
		input logic [KEY_W-1:0] exp);
	checks++;
	if (got !== exp)
		mismatch(name, 160'(got), 160'(exp));
endtask

task automatic check_word(input string name, input logic [BUS_W-1:0] got,
		input logic [BUS_W-1:0] exp);
	checks++;
	if (got !== exp)
		mismatch(name, 160'(got), 160'(exp));
endtask

// address and byte of one write, compared together
task automatic check_ioctl(input string name, input logic [IOCTL_AW+DATA_W-1:0] got,
		input logic [IOCTL_AW+DATA_W-1:0] exp);
	checks++;
	if (got !== exp)
		mismatch(name, 160'(got), 160'(exp));
endtask

task automatic check_buff(input string name, input logic [BUFF_AW+DATA_W-1:0] got,
		input logic [BUFF_AW+DATA_W-1:0] exp);
	checks++;
	if (got !== exp)
		mismatch(name, 160'(got), 160'(exp));
endtask

// ==== verification/hps_io_tb.sv ====
//////////////////////////////
// host I/O bridge testbench with LFSR stimulus and a reference model
//////////////////////////////
`timescale 1ns/1ns

module hps_io_tb import hps_pkg::*; ;

	logic                clk_sys;
	logic                rst_n;
	logic                io_strobe;
	logic                io_enable;
	logic                fp_enable;
	logic [BUS_W-1:0]    io_din;
	logic [BUS_W-1:0]    io_dout;
	logic [1:0]          buttons;
	logic                forced_scandoubler;
	logic [JOY_W-1:0]    joystick_0;
	logic [JOY_W-1:0]    joystick_1;
	logic [STATUS_W-1:0] status;
	logic [STATUS_W-1:0] status_in;
	logic                status_set;
	logic [KEY_W-1:0]    ps2_key;
	logic [31:0]         sd_lba [VDNUM];
	logic [VDNUM-1:0]    sd_rd;
	logic [VDNUM-1:0]    sd_wr;
	logic [VDNUM-1:0]    sd_ack;
	logic [BUFF_AW-1:0]  sd_buff_addr;
	logic [DATA_W-1:0]   sd_buff_dout;
	logic [DATA_W-1:0]   sd_buff_din [VDNUM];
	logic                sd_buff_wr;
	logic                ioctl_download;
	logic [15:0]         ioctl_index;
	logic [IOCTL_AW-1:0] ioctl_addr;
	logic [DATA_W-1:0]   ioctl_dout;
	logic                ioctl_wr;
	logic [31:0]         ioctl_file_ext;

	logic [31:0]                 lfsr;
	int                          errors;
	int                          test_errors;
	int                          checks;
	logic [BUS_W-1:0]            words_q [$];
	logic [BUS_W-1:0]            resp_q [$];
	logic [BUFF_AW+DATA_W-1:0]   sd_wr_q [$];
	logic [IOCTL_AW+DATA_W-1:0]  io_wr_q [$];
	logic [VDNUM-1:0]            ack_seen;

	logic [31:0]         j0;
	logic [31:0]         j1;
	logic [31:0]         raw;
	logic [31:0]         ext;
	logic [15:0]         cfg;
	logic [15:0]         idx;
	logic [STATUS_W-1:0] st_exp;
	logic [STATUS_W-1:0] sin_exp;
	logic [3:0]          set_cnt;
	logic [9:0]          key_exp;
	logic                tog;
	logic [1:0]          disk;
	logic [DATA_W-1:0]   bytes_q [$];
	logic [IOCTL_AW-1:0] start;
	int                  ptr;
	int                  pick;
	int                  len;

	hps_io dut_i (.*);

	`include "hps_tb_tasks.svh"

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1
	// stepped once for every bit returned
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	// sector contents seen by the bridge
	function automatic logic [DATA_W-1:0] fill_byte(input int d, input logic [BUFF_AW-1:0] a);
		return DATA_W'(a * 14'd29) ^ DATA_W'(a >> 6) ^ DATA_W'(d * 8'h41);
	endfunction

	function automatic int next_disk(input int p, input logic [3:0] rd, input logic [3:0] wr);
		int d;
		bit found;
		d = 0;
		found = 1'b0;
		for (int i = 0; i < VDNUM; i++) begin
			if (!found && (rd[(p + i) % VDNUM] || wr[(p + i) % VDNUM])) begin
				d = (p + i) % VDNUM;
				found = 1'b1;
			end
		end
		return d;
	endfunction

	always_comb begin
		for (int d = 0; d < VDNUM; d++)
			sd_buff_din[d] = fill_byte(d, sd_buff_addr);
	end

	// write monitors on the falling edge
	always @(negedge clk_sys) begin
		if (sd_buff_wr)
			sd_wr_q.push_back({sd_buff_addr, sd_buff_dout});
		if (ioctl_wr)
			io_wr_q.push_back({ioctl_addr, ioctl_dout});
		if (sd_ack != '0)
			ack_seen = sd_ack;
	end

	task automatic end_test(input string name);
		$display("test %s: %s, %0d errors", name, (test_errors != 0) ? "failed" : "passed",
			test_errors);
		test_errors = 0;
	endtask

	initial begin
		lfsr        = 32'hc525a505;
		errors      = 0;
		test_errors = 0;
		checks      = 0;
		tog         = 1'b0;
		rst_n      <= 1'b0;
		io_strobe  <= 1'b0;
		io_enable  <= 1'b0;
		fp_enable  <= 1'b0;
		io_din     <= '0;
		status_in  <= '0;
		status_set <= 1'b0;
		sd_rd      <= '0;
		sd_wr      <= '0;
		for (int d = 0; d < VDNUM; d++)
			sd_lba[d] <= '0;
		repeat (2) @(posedge clk_sys);
		rst_n <= 1'b1;
		for (int d = 0; d < VDNUM; d++)
			sd_lba[d] <= rand_bits(32);

		////////////////////////////////
		// joysticks and config word
		j0  = rand_bits(32);
		j1  = rand_bits(32);
		cfg = 16'(rand_bits(16));
		start_words({8'h00, CMD_JOY0});
		words_q.push_back(j0[15:0]);
		words_q.push_back(j0[31:16]);
		host_xfer(1'b0);
		start_words({8'h00, CMD_JOY1});
		words_q.push_back(j1[15:0]);
		words_q.push_back(j1[31:16]);
		host_xfer(1'b0);
		start_words({8'h00, CMD_CFG});
		words_q.push_back(cfg);
		host_xfer(1'b0);
		check_joy("joystick_0", joystick_0, j0);
		check_joy("joystick_1", joystick_1, j1);
		check_word("buttons", {14'b0, buttons}, {14'b0, cfg[1:0]});
		check_word("forced_scandoubler", {15'b0, forced_scandoubler}, {15'b0, cfg[4]});
		end_test("joystick and config");

		////////////////////////////////
		// status write and status-set read-back
		for (int k = 0; k < 4; k++) begin
			st_exp[32*k +: 32]  = rand_bits(32);
			sin_exp[32*k +: 32] = rand_bits(32);
		end
		start_words({8'h00, CMD_STATUS});
		for (int k = 0; k < 8; k++)
			words_q.push_back(st_exp[16*k +: 16]);
		host_xfer(1'b0);
		check_status("status", status, st_exp);
		@(posedge clk_sys);
		status_in  <= sin_exp;
		status_set <= 1'b1;
		@(posedge clk_sys);
		status_set <= 1'b0;
		set_cnt = 4'd1;
		start_words({8'h00, CMD_STATUS_GET});
		for (int k = 0; k < 8; k++)
			words_q.push_back('0);
		host_xfer(1'b0);
		check_word("io_dout", resp_q[0], {8'h00, 4'hA, set_cnt});
		for (int k = 0; k < 8; k++)
			check_word("io_dout", resp_q[k+1], sin_exp[16*k +: 16]);
		end_test("status");

		////////////////////////////////
		// keyboard events
		for (int s = 0; s < 4; s++) begin
			// pressed flag in bit 9, extended flag in bit 8
			case (s)
				0: begin
					raw     = 32'h0000001C;
					len     = 1;
					key_exp = 10'h21C;
				end
				1: begin
					raw     = 32'h0000E075;
					len     = 2;
					key_exp = 10'h375;
				end
				2: begin
					raw     = 32'h0000F01C;
					len     = 2;
					key_exp = 10'h01C;
				end
				default: begin
					raw     = 32'h00E0F075;
					len     = 3;
					key_exp = 10'h175;
				end
			endcase
			start_words({8'h00, CMD_KBD});
			for (int b = len - 1; b >= 0; b--)
				words_q.push_back({8'h00, raw[8*b +: 8]});
			host_xfer(1'b0);
			wait_key_change(ps2_key & 11'h3FF | {tog, 10'h000});
			tog = ~tog;
			check_key("ps2_key", ps2_key, {tog, key_exp});
		end
		end_test("keyboard");

		////////////////////////////////
		// round-robin status queries
		ptr = 0;
		for (int q = 0; q < 8; q++) begin
			@(posedge clk_sys);
			sd_rd <= 4'(rand_bits(4));
			sd_wr <= 4'(rand_bits(4));
			@(posedge clk_sys);
			pick = next_disk(ptr, sd_rd, sd_wr);
			start_words({8'h00, CMD_SD_STAT});
			for (int k = 0; k < 3; k++)
				words_q.push_back('0);
			host_xfer(1'b0);
			check_word("io_dout", resp_q[0],
				{1'b1, 10'b0, DISK_W'(pick), 1'b0, sd_wr[pick], sd_rd[pick]});
			check_word("io_dout", resp_q[2], sd_lba[pick][15:0]);
			check_word("io_dout", resp_q[3], sd_lba[pick][31:16]);
			ptr = (ptr + 1) % VDNUM;
		end
		@(posedge clk_sys);
		sd_rd <= '0;
		sd_wr <= '0;
		end_test("sd status");

		////////////////////////////////
		// sector write then read
		disk = 2'(rand_bits(2));
		ack_seen = '0;
		sd_wr_q.delete();
		bytes_q.delete();
		start_words({6'b0, disk, CMD_SD_WRITE});
		for (int k = 0; k < 6; k++) begin
			bytes_q.push_back(8'(rand_bits(8)));
			words_q.push_back({8'h00, bytes_q[k]});
		end
		host_xfer(1'b0);
		wait_writes(1'b0, 6);
		check_word("sd_ack", {12'b0, ack_seen}, {12'b0, 4'b0001 << disk});
		for (int k = 0; k < sd_wr_q.size() && k < 6; k++)
			check_buff("sd_buff_addr/dout", sd_wr_q[k], {BUFF_AW'(k), bytes_q[k]});
		start_words({6'b0, disk, CMD_SD_READ});
		for (int k = 0; k < 6; k++)
			words_q.push_back('0);
		host_xfer(1'b0);
		for (int k = 1; k <= 6; k++)
			check_word("io_dout", resp_q[k], {8'h00, fill_byte(disk, BUFF_AW'(k - 1))});
		end_test("sd transfer");

		////////////////////////////////
		// file download
		idx   = 16'(rand_bits(16));
		ext   = rand_bits(32);
		start = IOCTL_AW'(rand_bits(IOCTL_AW));
		io_wr_q.delete();
		start_words({8'h00, FIO_FILE_INDEX});
		words_q.push_back(idx);
		host_xfer(1'b1);
		start_words({8'h00, FIO_FILE_INFO});
		words_q.push_back(ext[31:16]);
		words_q.push_back(ext[15:0]);
		host_xfer(1'b1);
		start_words({8'h00, FIO_FILE_TX});
		words_q.push_back(16'h0001);
		words_q.push_back(start[15:0]);
		words_q.push_back({5'b0, start[IOCTL_AW-1:16]});
		host_xfer(1'b1);
		check_word("ioctl_download", {15'b0, ioctl_download}, 16'h0001);
		check_word("ioctl_index", ioctl_index, idx);
		check_joy("ioctl_file_ext", ioctl_file_ext, ext);
		bytes_q.delete();
		start_words({8'h00, FIO_FILE_TX_DAT});
		for (int k = 0; k < 8; k++) begin
			words_q.push_back(16'(rand_bits(16)));
			bytes_q.push_back(words_q[k+1][7:0]);
		end
		host_xfer(1'b1);
		wait_writes(1'b1, 8);
		for (int k = 0; k < io_wr_q.size() && k < 8; k++)
			check_ioctl("ioctl_addr/dout", io_wr_q[k], {start + IOCTL_AW'(k), bytes_q[k]});
		start_words({8'h00, FIO_FILE_TX});
		words_q.push_back(16'h0000);
		host_xfer(1'b1);
		wait_download_low();
		end_test("file download");

		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+verification
source/hps_pkg.sv
source/hps_bus_port.sv
source/user_cmd_decoder.sv
source/ps2_key_decoder.sv
source/sd_disk_arbiter.sv
source/file_loader.sv
source/hps_io.sv
verification/hps_io_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module hps_io_tb \
	-f project.f --Mdir obj_dir -o sim_hps_io
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_hps_io > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0
